// ==== rtl/snd_map_pkg.sv ====
// sound bus memory map, region codes and tone generator constants
package snd_map_pkg;

    // decoded bus regions, reg_none when no cycle is running
    typedef enum logic [2:0] {
        reg_rom,
        reg_tone,
        reg_mcu,
        reg_ram,
        reg_latch,
        reg_none
    } bus_region_e;

    localparam int ram_aw       = 11;   // 2 KB work ram
    localparam int region_shift = 13;   // region field is addr[15:13]

    // region field codes, rom is anything below rgn_tone (0xx)
    localparam logic [2:0] rgn_tone  = 3'b100;
    localparam logic [2:0] rgn_mcu   = 3'b101;
    localparam logic [2:0] rgn_ram   = 3'b110;
    localparam logic [2:0] rgn_latch = 3'b111;

    // tone generator
    localparam int tone_regs    = 4;    // two periods, two volumes
    localparam int sample_div   = 64;   // clocks per output sample
    localparam int sample_div_w = $clog2(sample_div);
    localparam int vol_shift    = 7;    // volume to amplitude

endpackage

// ==== rtl/snd_cpu_pkg.sv ====
// sound sequencer opcodes, fsm states and vector addresses
package snd_cpu_pkg;

    // one byte opcodes, operands follow low byte first
    typedef enum logic [7:0] {
        op_wait = 8'h00,    // park until nmi
        op_ldi  = 8'h01,    // acc = imm
        op_ld   = 8'h02,    // acc = mem[addr16]
        op_st   = 8'h03,    // mem[addr16] = acc
        op_addi = 8'h04,    // acc += imm
        op_xori = 8'h05,    // acc ^= imm
        op_jmp  = 8'h06,    // pc = addr16
        op_jnz  = 8'h07     // pc = addr16 if acc != 0
    } opcode_e;

    // sequencer steps
    typedef enum logic [2:0] {
        st_fetch,           // opcode byte from rom
        st_arg_lo,          // imm or address low byte
        st_arg_hi,          // address high byte
        st_exec,            // alu and branches
        st_mem,             // load/store cycle
        st_idle             // waiting for nmi
    } seq_state_e;

    localparam logic [15:0] reset_pc   = 16'h0000;
    localparam logic [15:0] nmi_vector = 16'h0066;  // same target as a z80 nmi

endpackage

// ==== rtl/snd_bus_decode.sv ====
// sound bus decoder, turns the address into region strobes and picks the read data
`timescale 1ns/10ps

module snd_bus_decode
    import snd_map_pkg::*;
(
    input  logic [15:0] bus_addr,
    input  logic        bus_req,
    input  logic        bus_we,
    input  logic [7:0]  ram_rdata,
    input  logic [7:0]  tone_rdata,
    input  logic [7:0]  rom_data,
    input  logic [7:0]  snd_latch,
    input  logic [7:0]  snd_din,
    output logic        rom_rd,
    output logic        ram_we,
    output logic        tone_we,
    output logic        snd_mcu_wr,
    output logic        snd_mcu_rd,
    output logic [7:0]  bus_rdata
);

    bus_region_e region;

    // region from the top three address bits, only during a bus cycle
    always_comb begin
        region = reg_none;
        if (bus_req) begin
            case (bus_addr[15:region_shift])
                rgn_tone:  region = reg_tone;
                rgn_mcu:   region = reg_mcu;
                rgn_ram:   region = reg_ram;
                rgn_latch: region = reg_latch;
                default:   region = reg_rom;   // 0xx
            endcase
        end
    end

    // one select per region, split by direction
    assign rom_rd     = (region == reg_rom) && !bus_we;    // rom is read only
    assign ram_we     = (region == reg_ram) && bus_we;
    assign tone_we    = (region == reg_tone) && bus_we;
    assign snd_mcu_wr = (region == reg_mcu) && bus_we;
    assign snd_mcu_rd = (region == reg_mcu) && !bus_we;

    // read mux, rom data when nothing else is selected
    always_comb begin
        case (region)
            reg_tone:  bus_rdata = tone_rdata;
            reg_latch: bus_rdata = snd_latch;  // command from the main cpu
            reg_ram:   bus_rdata = ram_rdata;  // registered in the ram
            reg_mcu:   bus_rdata = snd_din;
            default:   bus_rdata = rom_data;
        endcase
    end

endmodule

// ==== rtl/snd_seq_core.sv ====
// accumulator sequencer, fetches from rom with wait states and runs loads, stores, jumps
`timescale 1ns/10ps

module snd_seq_core
    import snd_cpu_pkg::*;
    import snd_map_pkg::*;
(
    input  logic        rom_cs,
    input  logic        reset,
    input  logic        nmi_n,
    input  logic [7:0]  bus_rdata,
    input  logic        rom_ok,
    output logic [15:0] bus_addr,
    output logic [7:0]  bus_wdata,
    output logic        bus_req,
    output logic        bus_we
);

    seq_state_e  state;
    opcode_e     opcode;        // current instruction
    opcode_e     fetched;       // byte on the bus seen as opcode
    logic [15:0] pc;
    logic [15:0] operand;       // imm in [7:0] or full address
    logic [7:0]  acc;
    logic        nmi_q;         // nmi_n one clock late
    logic        nmi_pend;      // falling edge seen, not yet taken
    logic        ram_wait;      // first cycle of a ram load
    logic        ram_ld;
    logic        rom_cyc;
    logic        stall;
    logic        two_byte;

    assign fetched  = opcode_e'(bus_rdata);
    assign two_byte = (opcode == op_ldi) || (opcode == op_addi) || (opcode == op_xori);

    // bus follows the state, so a stall holds it for free
    always_comb begin
        bus_req  = 1'b0;
        bus_we   = 1'b0;
        bus_addr = pc;
        case (state)
            st_fetch, st_arg_lo, st_arg_hi: bus_req = 1'b1;   // instruction bytes
            st_mem: begin
                bus_req  = 1'b1;
                bus_addr = operand;
                bus_we   = (opcode == op_st);
            end
            default: bus_req = 1'b0;
        endcase
    end

    assign bus_wdata = acc;     // stores always write the accumulator

    // only rom reads wait for rom_ok
    assign rom_cyc = bus_req && !bus_we && (bus_addr[15:region_shift] < rgn_tone);
    assign stall   = rom_cyc && !rom_ok;

    // ram read data shows up a clock after the address
    assign ram_ld = (state == st_mem) && (opcode == op_ld)
                    && (operand[15:region_shift] == rgn_ram);

    // control: state, pc, nmi tracking
    always_ff @(posedge rom_cs) begin
        if (reset) begin
            state    <= st_fetch;
            pc       <= reset_pc;
            nmi_q    <= 1'b1;
            nmi_pend <= 1'b0;
            ram_wait <= 1'b0;
        end else begin
            nmi_q <= nmi_n;
            if (!stall) begin
                case (state)
                    st_fetch: begin
                        if (nmi_pend) begin
                            pc       <= nmi_vector;     // fetched byte is dropped
                            nmi_pend <= 1'b0;
                        end else begin
                            pc <= pc + 16'd1;
                            case (fetched)
                                op_ldi, op_addi, op_xori,
                                op_ld, op_st, op_jmp, op_jnz: state <= st_arg_lo;
                                default: state <= st_idle;  // op_wait and unknown codes
                            endcase
                        end
                    end
                    st_arg_lo: begin
                        pc    <= pc + 16'd1;
                        state <= two_byte ? st_exec : st_arg_hi;
                    end
                    st_arg_hi: begin
                        pc    <= pc + 16'd1;
                        state <= st_exec;
                    end
                    st_exec: begin
                        state <= st_fetch;
                        case (opcode)
                            op_ld, op_st: state <= st_mem;
                            op_jmp:       pc <= operand;
                            op_jnz:       if (acc != 8'd0) pc <= operand;
                            default:      state <= st_fetch;   // alu ops done here
                        endcase
                    end
                    st_mem: begin
                        if (ram_ld && !ram_wait) begin
                            ram_wait <= 1'b1;       // one more cycle for ram data
                        end else begin
                            ram_wait <= 1'b0;
                            state    <= st_fetch;
                        end
                    end
                    st_idle: if (nmi_pend) state <= st_fetch;
                    default: state <= st_fetch;
                endcase
            end
            // a new edge wins over the clear above
            if (nmi_q && !nmi_n) nmi_pend <= 1'b1;
        end
    end

    // datapath registers
    always_ff @(posedge rom_cs) begin
        if (!stall) begin
            case (state)
                st_fetch:  opcode        <= fetched;
                st_arg_lo: operand[7:0]  <= bus_rdata;
                st_arg_hi: operand[15:8] <= bus_rdata;
                st_exec: begin
                    case (opcode)
                        op_ldi:  acc <= operand[7:0];
                        op_addi: acc <= acc + operand[7:0];
                        op_xori: acc <= acc ^ operand[7:0];
                        default: acc <= acc;
                    endcase
                end
                st_mem: if (opcode == op_ld && !(ram_ld && !ram_wait)) acc <= bus_rdata;
                default: acc <= acc;
            endcase
        end
    end

endmodule

// ==== rtl/snd_work_ram.sv ====
// sound cpu work ram, 2 KB with registered read
`timescale 1ns/10ps

module snd_work_ram
    import snd_map_pkg::*;
(
    input  logic              rom_cs,
    input  logic [ram_aw-1:0] addr,
    input  logic [7:0]        wdata,
    input  logic              we,
    output logic [7:0]        rdata
);

    logic [7:0] mem [2**ram_aw];

    always_ff @(posedge rom_cs) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];     // old data on a write cycle
    end

endmodule

// ==== rtl/snd_tone_gen.sv ====
// two channel square tone generator with register file and sample strobe
`timescale 1ns/10ps

module snd_tone_gen
    import snd_map_pkg::*;
(
    input  logic               rom_cs,
    input  logic               reset,
    input  logic               we,
    input  logic [1:0]         reg_addr,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata,
    output logic               sample,
    output logic signed [15:0] left,
    output logic signed [15:0] right
);

    logic [7:0]              regs [tone_regs];  // 0,1 periods; 2,3 volumes
    logic [sample_div_w-1:0] div_cnt;
    logic                    tick;
    logic [7:0]              ch_cnt   [2];      // samples into current half wave
    logic [7:0]              cnt_next [2];
    logic [1:0]              phase;             // 1 means positive half
    logic [1:0]              ph_next;
    logic signed [15:0]      amp      [2];

    assign rdata = regs[reg_addr];
    assign tick  = (div_cnt == sample_div_w'(sample_div - 1));

    // next counter and phase per channel, used on tick
    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            cnt_next[ch] = ch_cnt[ch] + 8'd1;
            ph_next[ch]  = phase[ch];
            if (regs[ch] == 8'd0) begin
                cnt_next[ch] = 8'd0;        // period 0 parks high
                ph_next[ch]  = 1'b1;
            end else if (ch_cnt[ch] >= regs[ch]) begin
                cnt_next[ch] = 8'd0;        // period+1 samples per half
                ph_next[ch]  = ~phase[ch];
            end
            amp[ch] = 16'(regs[2 + ch]) << vol_shift;
        end
    end

    always_ff @(posedge rom_cs) begin
        if (reset) begin
            for (int i = 0; i < tone_regs; i++) regs[i] <= 8'd0;
            div_cnt   <= '0;
            ch_cnt[0] <= 8'd0;
            ch_cnt[1] <= 8'd0;
            phase     <= 2'b00;
            sample    <= 1'b0;
            left      <= 16'sd0;
            right     <= 16'sd0;
        end else begin
            if (we) regs[reg_addr] <= wdata;
            sample  <= tick;                // outputs move with this pulse
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                ch_cnt <= cnt_next;
                phase  <= ph_next;
                left   <= ph_next[0] ? amp[0] : -amp[0];
                right  <= ph_next[1] ? amp[1] : -amp[1];
            end
        end
    end

endmodule

// ==== rtl/snd_sound_top.sv ====
// sound subsystem top, sequencer plus bus decode, work ram and tone generator
`timescale 1ns/10ps

module snd_sound_top
    import snd_map_pkg::*;
(
    input  logic               rom_cs,      // system clock
    input  logic               reset,
    input  logic               nmi_n,
    input  logic [7:0]         snd_latch,   // from main cpu
    input  logic [7:0]         snd_din,     // from mcu
    output logic [7:0]         snd_dout,
    output logic               snd_mcu_wr,
    output logic               snd_mcu_rd,
    output logic [14:0]        rom_addr,
    output logic               rom_rd,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    logic [15:0] bus_addr;
    logic [7:0]  bus_wdata;
    logic        bus_req;
    logic        bus_we;
    logic [7:0]  bus_rdata;
    logic [7:0]  ram_rdata;
    logic [7:0]  tone_rdata;
    logic        ram_we;
    logic        tone_we;

    assign rom_addr = bus_addr[14:0];   // 32 KB rom window
    assign snd_dout = bus_wdata;

    snd_seq_core i_seq (
        .rom_cs    (rom_cs),
        .reset     (reset),
        .nmi_n     (nmi_n),
        .bus_rdata (bus_rdata),
        .rom_ok    (rom_ok),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_req   (bus_req),
        .bus_we    (bus_we)
    );

    snd_bus_decode i_decode (
        .bus_addr   (bus_addr),
        .bus_req    (bus_req),
        .bus_we     (bus_we),
        .ram_rdata  (ram_rdata),
        .tone_rdata (tone_rdata),
        .rom_data   (rom_data),
        .snd_latch  (snd_latch),
        .snd_din    (snd_din),
        .rom_rd     (rom_rd),
        .ram_we     (ram_we),
        .tone_we    (tone_we),
        .snd_mcu_wr (snd_mcu_wr),
        .snd_mcu_rd (snd_mcu_rd),
        .bus_rdata  (bus_rdata)
    );

    snd_work_ram i_ram (
        .rom_cs (rom_cs),
        .addr   (bus_addr[ram_aw-1:0]),
        .wdata  (bus_wdata),
        .we     (ram_we),
        .rdata  (ram_rdata)
    );

    snd_tone_gen i_tone (
        .rom_cs   (rom_cs),
        .reset    (reset),
        .we       (tone_we),
        .reg_addr (bus_addr[1:0]),  // four registers, mirrored across the region
        .wdata    (bus_wdata),
        .rdata    (tone_rdata),
        .sample   (sample),
        .left     (left),
        .right    (right)
    );

endmodule

// ==== tb/snd_bus_assert.sv ====
// bus strobe assertions, bound into the sound top
`timescale 1ns/10ps

module snd_bus_assert (
    input logic        rom_cs,
    input logic        reset,
    input logic        rom_rd,
    input logic        rom_ok,
    input logic        snd_mcu_wr,
    input logic        snd_mcu_rd,
    input logic [15:0] bus_addr
);

    int fail_cnt = 0;   // failed assertions so far

    // at most one external strobe at a time
    a_strobe_excl: assert property (@(posedge rom_cs) disable iff (reset)
        $onehot0({rom_rd, snd_mcu_wr, snd_mcu_rd}))
        else begin
            $error("rom_rd, snd_mcu_wr and snd_mcu_rd overlap");
            fail_cnt++;
        end

    a_wr_pulse: assert property (@(posedge rom_cs) disable iff (reset)
        snd_mcu_wr |=> !snd_mcu_wr)
        else begin
            $error("snd_mcu_wr longer than one cycle");
            fail_cnt++;
        end

    a_rd_pulse: assert property (@(posedge rom_cs) disable iff (reset)
        snd_mcu_rd |=> !snd_mcu_rd)
        else begin
            $error("snd_mcu_rd longer than one cycle");
            fail_cnt++;
        end

    // rom wait state freezes the address
    a_stall_addr: assert property (@(posedge rom_cs) disable iff (reset)
        (rom_rd && !rom_ok) |=> $stable(bus_addr))
        else begin
            $error("bus_addr moved during a rom stall");
            fail_cnt++;
        end

endmodule

bind snd_sound_top snd_bus_assert i_bus_assert (
    .rom_cs     (rom_cs),
    .reset      (reset),
    .rom_rd     (rom_rd),
    .rom_ok     (rom_ok),
    .snd_mcu_wr (snd_mcu_wr),
    .snd_mcu_rd (snd_mcu_rd),
    .bus_addr   (bus_addr)
);

// ==== tb/snd_checker.sv ====
// result checker, watches the dut ports and compares mcu writes and tone samples
`timescale 1ns/10ps

module snd_checker
    import snd_map_pkg::*;
(
    input  logic               rom_cs,
    input  logic               reset,
    input  logic               nmi_n,
    input  logic [7:0]         snd_dout,
    input  logic               snd_mcu_wr,
    input  logic               snd_mcu_rd,
    input  logic [14:0]        rom_addr,
    input  logic               rom_rd,
    input  logic signed [15:0] left,
    input  logic signed [15:0] right,
    input  logic               sample,
    input  logic [7:0]         exp_wr0,     // latch ^ 0x5a
    input  logic [7:0]         exp_wr1,     // ram round trip plus one
    input  logic [7:0]         exp_wr2,     // mcu data echoed back
    input  logic [7:0]         exp_vol,     // left volume after the row
    output int                 errors,
    output int                 passed
);

    int          wr_idx;
    int          rd_cnt;
    int          row;
    int          row_errs;
    int          since_smp; // clocks since the last sample pulse
    logic        smp_seen;
    logic        pre_nmi;   // nothing but the reset fetch allowed yet
    logic        settled;   // volume known, samples checkable
    logic [7:0]  cur_vol;
    logic [7:0]  exp_val;
    logic signed [15:0] exp_amp;

    task automatic report(input string msg);
        $display("Fail %0t: %s", $time, msg);
        errors++;
        row_errs++;
    endtask

    always @(posedge rom_cs) begin
        if (reset) begin
            wr_idx = 0;
            rd_cnt = 0;
            row = 0;
            row_errs = 0;
            errors = 0;
            passed = 0;
            since_smp = 0;
            smp_seen = 1'b0;
            pre_nmi = 1'b1;
            settled = 1'b1;
            cur_vol = 8'd0;
        end else begin
            if (!nmi_n) begin               // new test starts
                pre_nmi  = 1'b0;
                settled  = 1'b0;
                wr_idx   = 0;
                rd_cnt   = 0;
                row_errs = 0;
            end
            if (pre_nmi && rom_rd && rom_addr != 15'd0)
                report($sformatf("fetch from %h before any nmi", rom_addr));
            if (pre_nmi && (snd_mcu_wr || snd_mcu_rd))
                report("mcu strobe before any nmi");
            if (pre_nmi && (left !== 16'sd0 || right !== 16'sd0))
                report($sformatf("left %0d right %0d before any nmi", left, right));
            if (snd_mcu_rd) rd_cnt++;
            if (snd_mcu_wr) begin
                case (wr_idx)
                    0:       exp_val = exp_wr0;
                    1:       exp_val = exp_wr1;
                    default: exp_val = exp_wr2;
                endcase
                if (wr_idx > 2)
                    report("extra mcu write after the third one");
                else if (snd_dout !== exp_val)
                    report($sformatf("mcu write %0d got %h expected %h",
                                     wr_idx, snd_dout, exp_val));
                if (wr_idx == 2) begin
                    if (rd_cnt != 1)
                        report($sformatf("%0d mcu reads before third write", rd_cnt));
                    cur_vol = exp_vol;
                    settled = 1'b1;
                    if (row_errs == 0) begin
                        passed++;
                        $display("test %0d ok", row);
                    end else begin
                        $display("test %0d failed with %0d errors", row, row_errs);
                    end
                    row++;
                end
                wr_idx++;
            end
            // one sample strobe every sample_div clocks
            since_smp++;
            if (sample) begin
                if (smp_seen && since_smp != sample_div)
                    report($sformatf("sample after %0d clocks expected %0d",
                                     since_smp, sample_div));
                smp_seen  = 1'b1;
                since_smp = 0;
            end
            // period 0 keeps the phase high, so left is +vol << 7
            if (sample && settled) begin
                exp_amp = {1'b0, cur_vol, 7'd0};
                if (left !== exp_amp)
                    report($sformatf("left %0d expected %0d", left, exp_amp));
                if (right !== 16'sd0)
                    report($sformatf("right %0d expected 0", right));
            end
        end
    end

endmodule

// ==== tb/snd_tb.sv ====
// sound subsystem testbench, clock, rom model with wait states and latch table
`timescale 1ns/10ps

module snd_tb
    import snd_cpu_pkg::*;
();

    localparam int n_rows = 6;

    logic               rom_cs;
    logic               reset;
    logic               nmi_n;
    logic [7:0]         snd_latch;
    logic [7:0]         snd_din;
    logic [7:0]         snd_dout;
    logic               snd_mcu_wr;
    logic               snd_mcu_rd;
    logic [14:0]        rom_addr;
    logic               rom_rd;
    logic [7:0]         rom_data = 8'h00;
    logic               rom_ok = 1'b0;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic               sample;
    logic [7:0]         exp_wr0;
    logic [7:0]         exp_wr1;
    logic [7:0]         exp_wr2;
    logic [7:0]         exp_vol;
    int                 errors;
    int                 passed;

    logic [7:0]  rom [32768];
    logic [31:0] rng = 32'h5d14;
    logic        rom_busy = 1'b0;
    int          rom_cnt;
    int          load_ptr;

    // stimulus table, expected columns filled from the program's rules
    logic [7:0] tbl_latch [n_rows] = '{8'h00, 8'h5a, 8'ha5, 8'h3c, 8'hff, 8'h81};
    logic [7:0] tbl_din   [n_rows] = '{8'h11, 8'h00, 8'hff, 8'hc3, 8'h7e, 8'h42};
    logic [7:0] tbl_wr0   [n_rows];
    logic [7:0] tbl_wr1   [n_rows];

    snd_sound_top i_dut (.*);

    snd_checker i_check (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic put_byte(input logic [7:0] b);
        rom[load_ptr] = b;
        load_ptr++;
    endtask

    task automatic put_imm(input opcode_e op, input logic [7:0] imm);
        put_byte(op);
        put_byte(imm);
    endtask

    task automatic put_abs(input opcode_e op, input logic [15:0] a);
        put_byte(op);
        put_byte(a[7:0]);    // low byte first
        put_byte(a[15:8]);
    endtask

    initial begin
        rom_cs = 1'b0;
        forever #5 rom_cs = ~rom_cs;
    end

    // rom answers after 0 to 3 extra cycles
    always @(posedge rom_cs) begin
        rom_ok <= 1'b0;
        if (!reset && rom_rd && !rom_ok) begin
            if (!rom_busy) begin
                rng = xorshift(rng);
                if (rng[1:0] == 2'd0) begin
                    rom_data <= rom[rom_addr];
                    rom_ok   <= 1'b1;
                end else begin
                    rom_busy <= 1'b1;
                    rom_cnt  <= int'(rng[1:0]) - 1;
                end
            end else if (rom_cnt == 0) begin
                rom_data <= rom[rom_addr];
                rom_ok   <= 1'b1;
                rom_busy <= 1'b0;
            end else begin
                rom_cnt <= rom_cnt - 1;
            end
        end
    end

    // watchdog
    initial begin
        repeat (n_rows * 400 + 5) @(posedge rom_cs);
        $display("timeout, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int wr_seen;
        reset = 1'b1;
        nmi_n = 1'b1;
        snd_latch = 8'h00;
        snd_din = 8'h00;
        exp_wr0 = 8'h00;
        exp_wr1 = 8'h00;
        exp_wr2 = 8'h00;
        exp_vol = 8'h00;
        for (int i = 0; i < 32768; i++) rom[i] = 8'(i ^ (i >> 7));  // filler
        rom[0] = op_wait;
        load_ptr = int'(nmi_vector);
        put_abs(op_ld, 16'he000);       // latch
        put_imm(op_xori, 8'h5a);
        put_abs(op_st, 16'ha000);       // mcu write 0
        put_abs(op_st, 16'hc010);       // ram
        put_abs(op_ld, 16'hc010);
        put_imm(op_addi, 8'h01);
        put_abs(op_st, 16'ha000);       // mcu write 1
        put_abs(op_st, 16'h8002);       // left volume
        put_abs(op_ld, 16'ha000);       // mcu read
        put_abs(op_st, 16'ha000);       // mcu write 2
        put_byte(op_wait);
        for (int r = 0; r < n_rows; r++) begin
            tbl_wr0[r] = tbl_latch[r] ^ 8'h5a;
            tbl_wr1[r] = tbl_wr0[r] + 8'd1;
        end
        repeat (5) @(posedge rom_cs);
        reset <= 1'b0;
        repeat (20) @(posedge rom_cs);  // idle, only the reset fetch
        for (int r = 0; r < n_rows; r++) begin
            @(posedge rom_cs);
            snd_latch <= tbl_latch[r];
            snd_din   <= tbl_din[r];
            exp_wr0   <= tbl_wr0[r];
            exp_wr1   <= tbl_wr1[r];
            exp_wr2   <= tbl_din[r];
            exp_vol   <= tbl_wr1[r];
            nmi_n     <= 1'b0;
            @(posedge rom_cs);
            nmi_n <= 1'b1;
            wr_seen = 0;
            while (wr_seen < 3) begin
                @(posedge rom_cs);
                if (snd_mcu_wr) wr_seen++;
            end
            repeat (2) begin            // let two samples through the checker
                @(posedge rom_cs);
                while (!sample) @(posedge rom_cs);
            end
        end
        @(posedge rom_cs);
        $display("tests %0d, passed %0d, errors %0d, assertion failures %0d",
                 n_rows, passed, errors, i_dut.i_bus_assert.fail_cnt);
        if (errors == 0 && passed == n_rows && i_dut.i_bus_assert.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
rtl/snd_map_pkg.sv
rtl/snd_cpu_pkg.sv
rtl/snd_bus_decode.sv
rtl/snd_seq_core.sv
rtl/snd_work_ram.sv
rtl/snd_tone_gen.sv
rtl/snd_sound_top.sv
tb/snd_bus_assert.sv
tb/snd_checker.sv
tb/snd_tb.sv

// ==== Makefile ====
# Verilator build and run for the sound subsystem testbench

VERILATOR ?= verilator
TOP       ?= snd_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
